// File: src/sifh_defines.svh
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// TDC timestamp and histogram geometry
`define SIFH_TS_W   10
`define SIFH_BIN_W  6                   // upper timestamp bits select the bin
`define SIFH_BINS   64
`define SIFH_CNT_W  16                  // same as event target, a bin cannot overflow

// AXI4-Lite register port
`define SIFH_AXI_AW 4
`define SIFH_AXI_DW 32

// byte offsets
`define SIFH_REG_CTRL   4'h0            // bit 0 starts a run
`define SIFH_REG_EVENTS 4'h4
`define SIFH_REG_STATUS 4'h8            // bit 0 busy, bit 1 done
`define SIFH_REG_PEAK   4'hC

// PEAK field placement
`define SIFH_PEAK_BIN_LSB 16

`endif

// File: src/sifhPkg.sv
`include "sifh_defines.svh"

package sifhPkg;

    typedef logic [`SIFH_BIN_W-1:0] binAddrT;   // histogram bin index
    typedef logic [`SIFH_CNT_W-1:0] binCountT;  // bin count or event count

    // sequencer phases
    typedef enum logic [2:0] {
        stIdle,
        stClear,
        stBuild,
        stDrain,
        stFind,
        stDone
    } ctrlStateT;

endpackage

// File: src/histRam.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module histRam (
    input  logic              clk,
    input  logic              wrEn,
    input  sifhPkg::binAddrT  wrAddr,
    input  sifhPkg::binCountT wrData,
    input  logic              rdEn,
    input  sifhPkg::binAddrT  rdAddr,
    output sifhPkg::binCountT rdData
);
    import sifhPkg::*;

    binCountT mem [`SIFH_BINS];          // one word per bin

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        if (rdEn) begin
            rdData <= mem[rdAddr];       // old data on an address collision
        end
    end

endmodule

// File: src/histBuilder.sv
`timescale 1ns/1ps

module histBuilder (
    input  logic              clk,
    input  logic              res,
    input  logic              hitValid,
    input  sifhPkg::binAddrT  hitBin,
    output logic              bldRdEn,
    output sifhPkg::binAddrT  bldRdAddr,
    output logic              bldWrEn,
    output sifhPkg::binAddrT  bldWrAddr,
    output sifhPkg::binCountT bldWrData,
    input  sifhPkg::binCountT ramRdData
);
    import sifhPkg::*;

    logic     rdPend;       // a read is in flight, data returns this cycle
    binAddrT  rdBin;        // bin of that read
    logic     lastWrEn;     // write issued one cycle earlier
    binAddrT  lastWrAddr;
    binCountT lastWrData;
    binCountT curCount;     // freshest count of rdBin

    // stage 1 issues the read straight from the hit
    assign bldRdEn   = hitValid;
    assign bldRdAddr = hitBin;

    // The SRAM misses the two most recent writes when its data comes back:
    // the one being written now and the one committed on the last edge.
    // The newer one wins.
    always_comb begin
        if (bldWrEn && (bldWrAddr == rdBin)) begin
            curCount = bldWrData;
        end else if (lastWrEn && (lastWrAddr == rdBin)) begin
            curCount = lastWrData;
        end else begin
            curCount = ramRdData;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdPend   <= 1'b0;
            bldWrEn  <= 1'b0;
            lastWrEn <= 1'b0;
        end else begin
            rdPend   <= hitValid;
            bldWrEn  <= rdPend;         // stage 2 writes one cycle after data
            lastWrEn <= bldWrEn;
        end
    end

    always_ff @(posedge clk) begin
        rdBin      <= hitBin;
        bldWrAddr  <= rdBin;
        bldWrData  <= curCount + binCountT'(1);
        lastWrAddr <= bldWrAddr;
        lastWrData <= bldWrData;
    end

endmodule

// File: src/peakFinder.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module peakFinder (
    input  logic              clk,
    input  logic              res,
    input  logic              scanStart,
    output logic              pfRdEn,
    output sifhPkg::binAddrT  pfRdAddr,
    input  sifhPkg::binCountT ramRdData,
    output logic              scanDone,
    output sifhPkg::binAddrT  scanBin,
    output sifhPkg::binCountT scanCount
);
    import sifhPkg::*;

    logic    cmpValid;      // ramRdData holds the count of cmpBin
    binAddrT cmpBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pfRdEn   <= 1'b0;
            pfRdAddr <= '0;
            cmpValid <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            if (scanStart) begin
                pfRdEn   <= 1'b1;
                pfRdAddr <= '0;
            end else if (pfRdEn) begin
                pfRdAddr <= pfRdAddr + binAddrT'(1);
                if (pfRdAddr == binAddrT'(`SIFH_BINS - 1)) begin
                    pfRdEn <= 1'b0;     // last bin issued
                end
            end
            cmpValid <= pfRdEn;
            scanDone <= cmpValid && (cmpBin == binAddrT'(`SIFH_BINS - 1));
        end
    end

    // strictly larger replaces, so a tie keeps the lower bin
    always_ff @(posedge clk) begin
        cmpBin <= pfRdAddr;
        if (cmpValid && ((cmpBin == '0) || (ramRdData > scanCount))) begin
            scanBin   <= cmpBin;
            scanCount <= ramRdData;
        end
    end

endmodule

// File: src/sifhCtrl.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module sifhCtrl (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  sifhPkg::binCountT     eventTarget,
    input  logic                  tsValid,
    input  logic [`SIFH_TS_W-1:0] tsData,
    output logic                  busy,
    output logic                  finish,
    output sifhPkg::binAddrT      peakBin,
    output sifhPkg::binCountT     peakCount,
    output logic                  tdcEn,
    output logic                  hitValid,
    output sifhPkg::binAddrT      hitBin,
    output logic                  scanStart,
    input  logic                  scanDone,
    input  sifhPkg::binAddrT      scanBin,
    input  sifhPkg::binCountT     scanCount,
    input  logic                  bldRdEn,
    input  sifhPkg::binAddrT      bldRdAddr,
    input  logic                  bldWrEn,
    input  sifhPkg::binAddrT      bldWrAddr,
    input  sifhPkg::binCountT     bldWrData,
    input  logic                  pfRdEn,
    input  sifhPkg::binAddrT      pfRdAddr,
    output logic                  ramWrEn,
    output sifhPkg::binAddrT      ramWrAddr,
    output sifhPkg::binCountT     ramWrData,
    output logic                  ramRdEn,
    output sifhPkg::binAddrT      ramRdAddr
);
    import sifhPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    binAddrT   clrAddr;
    binCountT  evTarget;            // captured at start
    binCountT  evCount;             // accepted timestamps
    logic      drainCnt;
    logic      lastHit;

    assign busy      = (state != stIdle);
    assign finish    = (state == stDone);
    assign tdcEn     = (state == stBuild);
    assign hitValid  = tdcEn && tsValid;        // dropped outside the build phase
    assign hitBin    = tsData[`SIFH_TS_W-1 -: `SIFH_BIN_W];
    assign lastHit   = hitValid && (evCount == evTarget - binCountT'(1));
    assign scanStart = (state == stDrain) && drainCnt;

    always_comb begin
        nextState = state;
        case (state)
            stIdle:  nextState = start ? stClear : stIdle;
            stClear: begin
                if (clrAddr == binAddrT'(`SIFH_BINS - 1)) begin
                    nextState = (evTarget == '0) ? stDrain : stBuild;
                end
            end
            stBuild: nextState = lastHit ? stDrain : stBuild;
            stDrain: nextState = drainCnt ? stFind : stDrain;
            stFind:  nextState = scanDone ? stDone : stFind;
            default: nextState = stIdle;            // stDone lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= stIdle;
            clrAddr  <= '0;
            evTarget <= '0;
            evCount  <= '0;
            drainCnt <= 1'b0;
        end else begin
            state <= nextState;
            if ((state == stIdle) && start) begin
                evTarget <= eventTarget;
                evCount  <= '0;
            end else if (hitValid) begin
                evCount <= evCount + binCountT'(1);
            end
            if (state == stClear) begin
                clrAddr <= clrAddr + binAddrT'(1);  // wraps back to 0 after the last bin
            end
            drainCnt <= (state == stDrain) && !drainCnt;
        end
    end

    always_ff @(posedge clk) begin
        if (scanDone) begin
            peakBin   <= scanBin;
            peakCount <= scanCount;
        end
    end

    // SRAM ownership follows the phase
    always_comb begin
        ramWrEn   = 1'b0;
        ramWrAddr = bldWrAddr;
        ramWrData = bldWrData;
        ramRdEn   = 1'b0;
        ramRdAddr = bldRdAddr;
        case (state)
            stClear: begin
                ramWrEn   = 1'b1;
                ramWrAddr = clrAddr;
                ramWrData = '0;
            end
            stBuild, stDrain: begin
                ramWrEn = bldWrEn;
                ramRdEn = bldRdEn;
            end
            stFind: begin
                ramRdEn   = pfRdEn;
                ramRdAddr = pfRdAddr;
            end
            default: ;
        endcase
    end

    // the drain phase must cover the builder pipeline
    bldWrInPhase: assert property (@(posedge clk) disable iff (!res)
        bldWrEn |-> (state == stBuild || state == stDrain));

endmodule

// File: src/sifhRegs.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module sifhRegs (
    input  logic                       clk,
    input  logic                       res,
    input  logic [`SIFH_AXI_AW-1:0]    awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`SIFH_AXI_DW-1:0]    wdata,
    input  logic [`SIFH_AXI_DW/8-1:0]  wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [`SIFH_AXI_AW-1:0]    araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`SIFH_AXI_DW-1:0]    rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       start,
    output sifhPkg::binCountT          eventTarget,
    input  logic                       busy,
    input  logic                       finish,
    input  sifhPkg::binAddrT           peakBin,
    input  sifhPkg::binCountT          peakCount
);
    import sifhPkg::*;

    logic                    wrTake;        // address and data both waiting
    logic                    rdTake;
    logic                    wrFire;
    logic                    rdFire;
    logic                    done;          // sticky until next start
    binAddrT                 peakBinQ;
    binCountT                peakCountQ;
    logic [`SIFH_AXI_DW-1:0] rdMux;

    // one transaction at a time, writes win a tie
    assign wrTake = awvalid && wvalid && !awready && !bvalid && !arready && !rvalid;
    assign rdTake = arvalid && !arready && !rvalid && !awready && !bvalid && !wrTake;
    assign wrFire = awvalid && awready && wvalid && wready;
    assign rdFire = arvalid && arready;

    assign bresp = 2'b00;                   // OKAY
    assign rresp = 2'b00;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wrTake;
            wready  <= wrTake;
            arready <= rdTake;
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            start       <= 1'b0;
            eventTarget <= '0;
            done        <= 1'b0;
            peakBinQ    <= '0;
            peakCountQ  <= '0;
        end else begin
            start <= wrFire && (awaddr == `SIFH_REG_CTRL) && wstrb[0] && wdata[0];
            if (wrFire && (awaddr == `SIFH_REG_EVENTS)) begin
                if (wstrb[0]) eventTarget[7:0]  <= wdata[7:0];
                if (wstrb[1]) eventTarget[15:8] <= wdata[15:8];
            end
            if (start) begin
                done <= 1'b0;
            end else if (finish) begin
                done <= 1'b1;
            end
            if (finish) begin
                peakBinQ   <= peakBin;
                peakCountQ <= peakCount;
            end
        end
    end

    always_comb begin
        rdMux = '0;                             // CTRL and holes read as zero
        case (araddr)
            `SIFH_REG_EVENTS: rdMux[`SIFH_CNT_W-1:0] = eventTarget;
            `SIFH_REG_STATUS: rdMux[1:0] = {done, busy};
            `SIFH_REG_PEAK: begin
                rdMux[`SIFH_CNT_W-1:0] = peakCountQ;
                rdMux[`SIFH_PEAK_BIN_LSB +: `SIFH_BIN_W] = peakBinQ;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rdata <= rdMux;
        end
    end

    // a response only follows an accepted request, with no other response pending
    bRiseHasReq: assert property (@(posedge clk) disable iff (!res)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready) && !rvalid);
    rRiseHasReq: assert property (@(posedge clk) disable iff (!res)
        $rose(rvalid) |-> $past(arvalid && arready) && !bvalid);

endmodule

// File: src/sifhTop.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module sifhTop (
    input  logic                      clk,
    input  logic                      res,
    input  logic [`SIFH_AXI_AW-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`SIFH_AXI_DW-1:0]   wdata,
    input  logic [`SIFH_AXI_DW/8-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`SIFH_AXI_AW-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`SIFH_AXI_DW-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      tsValid,
    input  logic [`SIFH_TS_W-1:0]     tsData,
    output logic                      tdcEn
);
    import sifhPkg::*;

    logic     start, busy, finish;          // register block to sequencer
    binCountT eventTarget, peakCount;
    binAddrT  peakBin;
    logic     hitValid, scanStart, scanDone;
    binAddrT  hitBin, scanBin;
    binCountT scanCount;
    logic     bldRdEn, bldWrEn, pfRdEn;     // port requests
    binAddrT  bldRdAddr, bldWrAddr, pfRdAddr;
    binCountT bldWrData;
    logic     ramWrEn, ramRdEn;             // muxed SRAM side
    binAddrT  ramWrAddr, ramRdAddr;
    binCountT ramWrData, ramRdData;

    sifhRegs    u_regs    (.*);
    sifhCtrl    u_ctrl    (.*);
    histBuilder u_builder (.*);
    peakFinder  u_finder  (.*);

    histRam u_ram (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

endmodule

// File: sim/axiLiteBfm.svh
`ifndef AXI_LITE_BFM_SVH
`define AXI_LITE_BFM_SVH

// single AXI4-Lite write, valids held until the slave takes both
task automatic axiWrite(input logic [`SIFH_AXI_AW-1:0] addr,
                        input logic [`SIFH_AXI_DW-1:0] data);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    @(posedge clk);
    while (!(awready && wready)) @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    if (bresp !== 2'b00) begin          // every register answers OKAY
        testCount++;
        failCount++;
        $display("Error write response at 0x%h: expected %b, actual %b", addr, 2'b00, bresp);
    end
    bready <= 1'b0;
endtask

task automatic axiRead(input  logic [`SIFH_AXI_AW-1:0] addr,
                       output logic [`SIFH_AXI_DW-1:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    data = rdata;                   // value before the edge, slave drops rvalid here
    if (rresp !== 2'b00) begin
        testCount++;
        failCount++;
        $display("Error read response at 0x%h: expected %b, actual %b", addr, 2'b00, rresp);
    end
    rready <= 1'b0;
endtask

task automatic checkPeak(input string name, input binAddrT expBin, input binCountT expCount,
                         input binAddrT actBin, input binCountT actCount);
    testCount++;
    if ((actBin !== expBin) || (actCount !== expCount)) begin
        failCount++;
        $display("Error %s: expected bin %0d count %0d, actual bin %0d count %0d",
                 name, expBin, expCount, actBin, actCount);
    end else begin
        $display("pass  %s: bin %0d count %0d", name, actBin, actCount);
    end
endtask

task automatic checkWord(input string name, input logic [`SIFH_AXI_DW-1:0] expVal,
                         input logic [`SIFH_AXI_DW-1:0] actVal);
    testCount++;
    if (actVal !== expVal) begin
        failCount++;
        $display("Error %s: expected 0x%08h, actual 0x%08h", name, expVal, actVal);
    end else begin
        $display("pass  %s: 0x%08h", name, actVal);
    end
endtask

task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    testCount++;
    if (actVal !== expVal) begin
        failCount++;
        $display("Error %s: expected %b, actual %b", name, expVal, actVal);
    end else begin
        $display("pass  %s: %b", name, actVal);
    end
endtask

`endif

// File: sim/sifhTb.sv
`timescale 1ns/1ps
`include "sifh_defines.svh"

module sifhTb;
    import sifhPkg::*;

    localparam int ROWS = 5;
    localparam int LOW_W = `SIFH_TS_W - `SIFH_BIN_W;   // timestamp bits below the bin
    localparam int CYCLE_LIMIT = ROWS * (`SIFH_BINS + 16 * 4 + 66 + 50);

    logic                      clk, res;
    logic [`SIFH_AXI_AW-1:0]   awaddr, araddr;
    logic                      awvalid, awready, wvalid, wready;
    logic [`SIFH_AXI_DW-1:0]   wdata, rdata;
    logic [`SIFH_AXI_DW/8-1:0] wstrb;
    logic [1:0]                bresp, rresp;
    logic                      bvalid, bready, arvalid, arready, rvalid, rready;
    logic                      tsValid, tdcEn;
    logic [`SIFH_TS_W-1:0]     tsData;

    int          testCount = 0;
    int          failCount = 0;
    int          cycleCount = 0;

    // stimulus table, one row per histogram run
    string   rowName   [ROWS];
    int      rowTarget [ROWS];
    binAddrT rowBins   [ROWS][16];
    logic    rowGaps   [ROWS];      // random idle cycles between hits
    logic    rowNoise  [ROWS];      // timestamps sent during the clear phase

    `include "axiLiteBfm.svh"

    sifhTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic loadTable();
        rowName   = '{"single winner", "tie lower bin", "back to back", "clear and drop",
                      "alternate bins"};
        rowTarget = '{10, 8, 16, 6, 12};
        rowGaps   = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
        rowNoise  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        rowBins[0] = '{6'd12, 6'd12, 6'd12, 6'd12, 6'd3, 6'd40, 6'd12, 6'd3,
                       6'd63, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0};
        rowBins[1] = '{6'd50, 6'd20, 6'd50, 6'd20, 6'd7, 6'd50, 6'd20, 6'd33,
                       6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0};
        rowBins[3] = '{6'd9, 6'd9, 6'd2, 6'd9, 6'd61, 6'd2, 6'd0, 6'd0,
                       6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0};
        for (int i = 0; i < 16; i++) begin
            rowBins[2][i] = 6'd37;                      // every hit on one bin
            rowBins[4][i] = (i % 2 == 0) ? 6'd4 : 6'd5;
        end
    endtask

    // reference histogram, highest count wins and the lower bin takes a tie
    function automatic void expectPeak(input int r, output binAddrT expBin,
                                       output binCountT expCount);
        int hist [`SIFH_BINS];
        int best;
        foreach (hist[b]) hist[b] = 0;
        for (int i = 0; i < rowTarget[r]; i++) begin
            hist[rowBins[r][i]]++;
        end
        best = 0;
        for (int b = 1; b < `SIFH_BINS; b++) begin
            if (hist[b] > hist[best]) best = b;
        end
        expBin   = binAddrT'(best);
        expCount = binCountT'(hist[best]);
    endfunction

    task automatic sendNoise(input int n);
        repeat (n) begin
            tsValid <= 1'b1;
            tsData  <= `SIFH_TS_W'($urandom);
            @(posedge clk);
        end
        tsValid <= 1'b0;
        checkFlag("tdcEn low during clear", 1'b0, tdcEn);
    endtask

    task automatic streamRow(input int r);
        logic [LOW_W-1:0] lowBits;
        int               gap;
        @(posedge clk);
        while (!tdcEn) @(posedge clk);  // clear phase still running
        for (int i = 0; i < rowTarget[r]; i++) begin
            lowBits = LOW_W'($urandom);
            tsValid <= 1'b1;
            tsData  <= {rowBins[r][i], lowBits};
            @(posedge clk);
            gap = rowGaps[r] ? int'($urandom % 3) : 0;
            if (gap > 0) begin
                tsValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        tsValid <= 1'b0;
    endtask

    task automatic runRow(input int r);
        logic [`SIFH_AXI_DW-1:0] d;
        binAddrT                 expBin;
        binCountT                expCount;
        expectPeak(r, expBin, expCount);
        axiWrite(`SIFH_REG_EVENTS, rowTarget[r]);
        axiWrite(`SIFH_REG_CTRL, 32'h1);
        if (rowNoise[r]) sendNoise(6);                  // well inside the 64 clear cycles
        streamRow(r);
        axiRead(`SIFH_REG_STATUS, d);
        while (!d[1]) axiRead(`SIFH_REG_STATUS, d);
        checkWord({rowName[r], " status"}, 32'h2, d);     // done and not busy
        axiRead(`SIFH_REG_PEAK, d);
        checkPeak({rowName[r], " peak"}, expBin, expCount,
                  d[`SIFH_PEAK_BIN_LSB +: `SIFH_BIN_W], d[`SIFH_CNT_W-1:0]);
    endtask

    initial begin
        logic [`SIFH_AXI_DW-1:0] d;
        void'($urandom(25));
        res     = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        tsValid = 1'b0;
        tsData  = '0;
        loadTable();
        repeat (2) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        checkFlag("tdcEn after reset", 1'b0, tdcEn);
        axiRead(`SIFH_REG_STATUS, d);
        checkWord("STATUS after reset", 32'h0, d);
        axiRead(`SIFH_REG_EVENTS, d);
        checkWord("EVENTS after reset", 32'h0, d);
        axiWrite(`SIFH_REG_EVENTS, 32'h1234);
        axiRead(`SIFH_REG_EVENTS, d);
        checkWord("EVENTS readback", 32'h1234, d);
        axiWrite(`SIFH_REG_CTRL, 32'hFFFF_FFFE);         // bit 0 clear, no run starts
        axiRead(`SIFH_REG_CTRL, d);
        checkWord("CTRL reads zero", 32'h0, d);
        for (int r = 0; r < ROWS; r++) begin
            runRow(r);
        end
        $display("Checks run: %0d, passed: %0d, failed: %0d",
                 testCount, testCount - failCount, failCount);
        if (failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
+incdir+sim
src/sifhPkg.sv
src/histRam.sv
src/histBuilder.sv
src/peakFinder.sv
src/sifhCtrl.sv
src/sifhRegs.sv
src/sifhTop.sv
sim/sifhTb.sv
